/* bpfcap.f */
bpfcap_pkg.sv
bpfcap_regs.sv
bpfcap_reader.sv
bpfcap_filter.sv
bpfcap_top.sv
bpfcap_chk.sv
tb_top.sv

/* run.sh */
#!/bin/bash
# build with Verilator, run, then decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f bpfcap.f -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    || echo "build or simulation exited with an error"
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top import bpfcap_pkg::*; ();

    logic     clk = 1'b0;
    logic     rst;
    reg_idx_t avs_s0_address;
    logic     avs_s0_write;
    word_t    avs_s0_writedata;
    logic     avs_s0_read;
    word_t    avs_s0_readdata;
    addr_t    avs_m0_address;
    logic     avs_m0_read;
    word_t    avs_m0_readdata;
    addr_t    avs_m1_address;
    logic     avs_m1_write;
    word_t    avs_m1_writedata;

    // packet memory indexed by address bits 9:2
    word_t       src_mem [0:255];
    logic [31:0] lcg_state = 32'h1d77_fbb7;

    // every write master access in order
    addr_t cap_addr [$];
    word_t cap_data [$];
    word_t exp_data [$];
    int    read_strobes = 0;
    int    write_strobes = 0;

    bpfcap_top #(
        .count_width (16)
    ) dut0 (
        .clk              (clk),
        .rst              (rst),
        .avs_s0_address   (avs_s0_address),
        .avs_s0_write     (avs_s0_write),
        .avs_s0_writedata (avs_s0_writedata),
        .avs_s0_read      (avs_s0_read),
        .avs_s0_readdata  (avs_s0_readdata),
        .avs_m0_address   (avs_m0_address),
        .avs_m0_read      (avs_m0_read),
        .avs_m0_readdata  (avs_m0_readdata),
        .avs_m1_address   (avs_m1_address),
        .avs_m1_write     (avs_m1_write),
        .avs_m1_writedata (avs_m1_writedata)
    );

    always #10 clk = ~clk;

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // memory answers a read one cycle later and logs writes as they happen
    initial begin : memory_model
        logic  rd_pending;
        addr_t rd_addr;
        rd_pending = 1'b0;
        rd_addr = '0;
        avs_m0_readdata = '0;
        forever begin
            @(posedge clk);
            #2;
            if (rd_pending) begin
                avs_m0_readdata = src_mem[rd_addr[9:2]];
            end
            rd_pending = (avs_m0_read === 1'b1);
            rd_addr = avs_m0_address;
            if (avs_m0_read === 1'b1) begin
                read_strobes++;
            end
            if (avs_m1_write === 1'b1) begin
                cap_addr.push_back(avs_m1_address);
                cap_data.push_back(avs_m1_writedata);
                write_strobes++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check(word_t actual, word_t expected, string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s, expected %h, got %h", $time, what, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic reg_write(reg_idx_t idx, word_t data);
        avs_s0_address = idx;
        avs_s0_writedata = data;
        avs_s0_write = 1'b1;
        next_cycle();
        avs_s0_write = 1'b0;
    endtask

    // readdata is registered, so it is taken one cycle after the strobe
    task automatic reg_read(reg_idx_t idx, output word_t data);
        avs_s0_address = idx;
        avs_s0_read = 1'b1;
        next_cycle();
        avs_s0_read = 1'b0;
        data = avs_s0_readdata;
    endtask

    task automatic configure(addr_t first, addr_t last, word_t match, word_t mask, addr_t dst);
        reg_write(reg_pkt_begin, first);
        reg_write(reg_pkt_end, last);
        reg_write(reg_match, match);
        reg_write(reg_mask, mask);
        reg_write(reg_dst_base, dst);
    endtask

    // busy shows up two cycles after the start write
    task automatic start_capture();
        word_t status;
        reg_write(reg_control, 32'd1);
        next_cycle();
        reg_read(reg_control, status);
        check({31'd0, status[1]}, 32'd1, "busy after start");
    endtask

    task automatic wait_idle();
        word_t status;
        int    polls;
        status = 32'd2;
        polls = 0;
        while (status[1] && polls < 200) begin
            reg_read(reg_control, status);
            polls++;
        end
        if (status[1]) begin
            $display("capture never finished, busy still set after %0d status reads", polls);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    endtask

    // in-order list of words whose masked bits equal the masked match value
    task automatic build_expected(addr_t first, addr_t last, word_t match, word_t mask);
        addr_t a;
        word_t w;
        exp_data.delete();
        a = first;
        while (a < last) begin
            w = src_mem[a[9:2]];
            if ((w & mask) == (match & mask)) begin
                exp_data.push_back(w);
            end
            a = a + 32'd4;
        end
    endtask

    task automatic compare_captures(int first, addr_t dst, string what);
        check(cap_data.size() - first, exp_data.size(), {what, " capture length"});
        for (int i = 0; i < exp_data.size(); i++) begin
            check(cap_addr[first + i], dst + 4 * i, {what, " write address"});
            check(cap_data[first + i], exp_data[i], {what, " write data"});
        end
    endtask

    task automatic reset_readback();
        word_t rd;
        reg_read(reg_control, rd);
        check(rd, 32'd0, "control after reset");
        reg_read(reg_count, rd);
        check(rd, 32'd0, "count after reset");
        configure(32'h0000_1230, 32'h0000_4560, 32'hcafe_f00d, 32'h0ff0_0ff0, 32'h8000_0040);
        reg_read(reg_pkt_begin, rd);
        check(rd, 32'h0000_1230, "pkt_begin readback");
        reg_read(reg_pkt_end, rd);
        check(rd, 32'h0000_4560, "pkt_end readback");
        reg_read(reg_match, rd);
        check(rd, 32'hcafe_f00d, "match readback");
        reg_read(reg_mask, rd);
        check(rd, 32'h0ff0_0ff0, "mask readback");
        reg_read(reg_dst_base, rd);
        check(rd, 32'h8000_0040, "dst_base readback");
    endtask

    task automatic pass_all_capture();
        word_t rd;
        int    first;
        first = cap_data.size();
        configure(32'h0000_0040, 32'h0000_0080, 32'hffff_ffff, 32'h0, 32'h1000_0000);
        build_expected(32'h0000_0040, 32'h0000_0080, 32'hffff_ffff, 32'h0);
        start_capture();
        wait_idle();
        compare_captures(first, 32'h1000_0000, "pass-all");
        reg_read(reg_count, rd);
        check(rd, 32'd16, "pass-all count");
    endtask

    task automatic masked_capture();
        word_t rd;
        word_t match_v;
        word_t mask_v;
        int    first;
        match_v = 32'h1234_5601;
        mask_v = 32'h0000_0083;
        first = cap_data.size();
        // two planted hits so the list is never empty
        src_mem[69] = (src_mem[69] & ~mask_v) | (match_v & mask_v);
        src_mem[84] = (src_mem[84] & ~mask_v) | (match_v & mask_v);
        configure(32'h0000_0100, 32'h0000_0180, match_v, mask_v, 32'h2000_0100);
        build_expected(32'h0000_0100, 32'h0000_0180, match_v, mask_v);
        start_capture();
        wait_idle();
        compare_captures(first, 32'h2000_0100, "masked");
        reg_read(reg_count, rd);
        check(rd, exp_data.size(), "masked count");
    endtask

    task automatic empty_range();
        word_t rd;
        int    r0;
        int    w0;
        configure(32'h0000_0200, 32'h0000_0200, 32'h0, 32'h0, 32'h3000_0000);
        r0 = read_strobes;
        w0 = write_strobes;
        start_capture();
        wait_idle();
        check(read_strobes - r0, 0, "reads on empty range");
        check(write_strobes - w0, 0, "writes on empty range");
        reg_read(reg_control, rd);
        check(rd, 32'd0, "control after empty range");
        reg_read(reg_count, rd);
        check(rd, 32'd0, "count after empty range");
    endtask

    task automatic start_while_busy();
        word_t rd;
        int    first;
        int    r0;
        configure(32'h0000_0040, 32'h0000_0080, 32'h0, 32'h0, 32'h4000_0000);
        build_expected(32'h0000_0040, 32'h0000_0080, 32'h0, 32'h0);
        first = cap_data.size();
        r0 = read_strobes;
        start_capture();
        // lands in the middle of the fetch
        reg_write(reg_control, 32'd1);
        wait_idle();
        compare_captures(first, 32'h4000_0000, "start while busy");
        check(read_strobes - r0, 16, "reads of a single run");
        reg_read(reg_count, rd);
        check(rd, 32'd16, "count of a single run");
        // shorter range on restart so a stale count would show
        reg_write(reg_pkt_end, 32'h0000_0060);
        build_expected(32'h0000_0040, 32'h0000_0060, 32'h0, 32'h0);
        first = cap_data.size();
        start_capture();
        wait_idle();
        compare_captures(first, 32'h4000_0000, "restart");
        reg_read(reg_count, rd);
        check(rd, 32'd8, "count after restart");
    endtask

    initial begin
        rst = 1'b1;
        avs_s0_address = reg_control;
        avs_s0_write = 1'b0;
        avs_s0_writedata = '0;
        avs_s0_read = 1'b0;
        for (int i = 0; i < 256; i++) begin
            src_mem[i] = lcg_next();
        end
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_readback();
        pass_all_capture();
        masked_capture();
        empty_range();
        start_while_busy();
        $display("Test OK");
        $finish;
    end

endmodule

/* bpfcap_chk.sv */
`timescale 1ns/1ps

module bpfcap_chk import bpfcap_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  start,
    input logic  busy,
    input addr_t pkt_begin,
    input addr_t pkt_end,
    input addr_t avs_m0_address,
    input logic  avs_m0_read,
    input logic  avs_m1_write
);

    // both masters quiet once reset has been taken
    quiet_in_reset: assert property (@(posedge clk) $past(rst) |-> !avs_m0_read && !avs_m1_write)
        else $error("master strobe high during reset");

    // read, readdata, write stage
    write_after_read: assert property (@(posedge clk) disable iff (rst)
        avs_m1_write |-> $past(avs_m0_read, 2))
        else $error("write strobe without a read two cycles earlier");

    read_in_range: assert property (@(posedge clk) disable iff (rst)
        avs_m0_read |-> (avs_m0_address >= pkt_begin) && (avs_m0_address < pkt_end))
        else $error("read address outside the packet range");

    busy_after_start: assert property (@(posedge clk) disable iff (rst) start |=> busy)
        else $error("busy did not follow start");

endmodule

bind bpfcap_top bpfcap_chk chk0 (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .busy           (busy),
    .pkt_begin      (pkt_begin),
    .pkt_end        (pkt_end),
    .avs_m0_address (avs_m0_address),
    .avs_m0_read    (avs_m0_read),
    .avs_m1_write   (avs_m1_write)
);

/* bpfcap_top.sv */
`timescale 1ns/1ps

module bpfcap_top import bpfcap_pkg::*; #(
    parameter int count_width = 16
) (
    input  logic     clk,
    input  logic     rst,

    // host slave
    input  reg_idx_t avs_s0_address,
    input  logic     avs_s0_write,
    input  word_t    avs_s0_writedata,
    input  logic     avs_s0_read,
    output word_t    avs_s0_readdata,

    // packet read master
    output addr_t    avs_m0_address,
    output logic     avs_m0_read,
    input  word_t    avs_m0_readdata,

    // capture write master
    output addr_t    avs_m1_address,
    output logic     avs_m1_write,
    output word_t    avs_m1_writedata
);

    logic                   start;
    logic                   busy;
    addr_t                  pkt_begin;
    addr_t                  pkt_end;
    word_t                  match;
    word_t                  mask;
    addr_t                  dst_base;
    logic                   data_valid;
    word_t                  data_word;
    logic [count_width-1:0] capture_count;

    bpfcap_regs #(
        .count_width (count_width)
    ) regs0 (
        .clk              (clk),
        .rst              (rst),
        .avs_s0_address   (avs_s0_address),
        .avs_s0_write     (avs_s0_write),
        .avs_s0_writedata (avs_s0_writedata),
        .avs_s0_read      (avs_s0_read),
        .avs_s0_readdata  (avs_s0_readdata),
        .busy             (busy),
        .capture_count    (capture_count),
        .start            (start),
        .pkt_begin        (pkt_begin),
        .pkt_end          (pkt_end),
        .match            (match),
        .mask             (mask),
        .dst_base         (dst_base)
    );

    bpfcap_reader reader0 (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .pkt_begin       (pkt_begin),
        .pkt_end         (pkt_end),
        .avs_m0_address  (avs_m0_address),
        .avs_m0_read     (avs_m0_read),
        .avs_m0_readdata (avs_m0_readdata),
        .data_valid      (data_valid),
        .data_word       (data_word),
        .busy            (busy)
    );

    // start doubles as the clear of count and write pointer
    bpfcap_filter #(
        .count_width (count_width)
    ) filter0 (
        .clk              (clk),
        .rst              (rst),
        .clear            (start),
        .data_valid       (data_valid),
        .data_word        (data_word),
        .match            (match),
        .mask             (mask),
        .dst_base         (dst_base),
        .avs_m1_address   (avs_m1_address),
        .avs_m1_write     (avs_m1_write),
        .avs_m1_writedata (avs_m1_writedata),
        .capture_count    (capture_count)
    );

endmodule

/* bpfcap_filter.sv */
`timescale 1ns/1ps

module bpfcap_filter import bpfcap_pkg::*; #(
    parameter int count_width = 16
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   clear,
    input  logic                   data_valid,
    input  word_t                  data_word,
    input  word_t                  match,
    input  word_t                  mask,
    input  addr_t                  dst_base,

    output addr_t                  avs_m1_address,
    output logic                   avs_m1_write,
    output word_t                  avs_m1_writedata,

    output logic [count_width-1:0] capture_count
);

    logic        hit;
    logic [29:0] wr_idx;

    // only the bits under the mask take part in the compare
    assign hit = ((data_word ^ match) & mask) == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            avs_m1_write  <= 1'b0;
            wr_idx        <= '0;
            capture_count <= '0;
        end else if (clear) begin
            avs_m1_write  <= 1'b0;
            wr_idx        <= '0;
            capture_count <= '0;
        end else begin
            avs_m1_write <= data_valid && hit;
            if (data_valid && hit) begin
                wr_idx        <= wr_idx + 30'd1;
                capture_count <= capture_count + 1'b1;
            end
        end
    end

    // write payload, consecutive words from dst_base
    always_ff @(posedge clk) begin
        if (data_valid && hit) begin
            avs_m1_address   <= dst_base + {wr_idx, 2'b00};
            avs_m1_writedata <= data_word;
        end
    end

endmodule

/* bpfcap_reader.sv */
`timescale 1ns/1ps

module bpfcap_reader import bpfcap_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  start,
    input  addr_t pkt_begin,
    input  addr_t pkt_end,

    output addr_t avs_m0_address,
    output logic  avs_m0_read,
    input  word_t avs_m0_readdata,

    output logic  data_valid,
    output word_t data_word,
    output logic  busy
);

    reader_state_t state;
    addr_t         ptr;
    addr_t         ptr_next;
    logic          drain_cnt;

    assign ptr_next = ptr + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            drain_cnt <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    drain_cnt <= 1'b0;
                    if (start) begin
                        // empty range skips straight to the drain
                        state <= (pkt_begin < pkt_end) ? fetch : drain;
                    end
                end
                fetch: begin
                    if (ptr_next >= pkt_end) begin
                        state <= drain;
                    end
                end
                drain: begin
                    // two cycles cover the readdata and the write stage
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // address pointer, loaded on start
    always_ff @(posedge clk) begin
        if (state == idle) begin
            ptr <= pkt_begin;
        end else if (state == fetch) begin
            ptr <= ptr_next;
        end
    end

    assign avs_m0_read    = (state == fetch);
    assign avs_m0_address = ptr;
    assign busy           = (state != idle);

    // memory answers one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= avs_m0_read;
        end
    end

    assign data_word = avs_m0_readdata;

endmodule

/* bpfcap_regs.sv */
`timescale 1ns/1ps

module bpfcap_regs import bpfcap_pkg::*; #(
    parameter int count_width = 16
) (
    input  logic                   clk,
    input  logic                   rst,

    input  reg_idx_t               avs_s0_address,
    input  logic                   avs_s0_write,
    input  word_t                  avs_s0_writedata,
    input  logic                   avs_s0_read,
    output word_t                  avs_s0_readdata,

    input  logic                   busy,
    input  logic [count_width-1:0] capture_count,

    output logic                   start,
    output addr_t                  pkt_begin,
    output addr_t                  pkt_end,
    output word_t                  match,
    output word_t                  mask,
    output addr_t                  dst_base
);

    logic  start_req;
    word_t read_mux;

    // a start is only taken when nothing runs and no pulse is pending
    assign start_req = avs_s0_write && (avs_s0_address == reg_control) &&
                       avs_s0_writedata[0] && !busy && !start;

    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= start_req;
        end
    end

    // configuration registers
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_begin <= '0;
            pkt_end   <= '0;
            match     <= '0;
            mask      <= '0;
            dst_base  <= '0;
        end else if (avs_s0_write) begin
            case (avs_s0_address)
                reg_pkt_begin: pkt_begin <= avs_s0_writedata;
                reg_pkt_end:   pkt_end   <= avs_s0_writedata;
                reg_match:     match     <= avs_s0_writedata;
                reg_mask:      mask      <= avs_s0_writedata;
                reg_dst_base:  dst_base  <= avs_s0_writedata;
                default: ;
            endcase
        end
    end

    // read mux, count is zero-extended
    always_comb begin
        read_mux = '0;
        case (avs_s0_address)
            reg_control:   read_mux[1] = busy;
            reg_pkt_begin: read_mux = pkt_begin;
            reg_pkt_end:   read_mux = pkt_end;
            reg_match:     read_mux = match;
            reg_mask:      read_mux = mask;
            reg_dst_base:  read_mux = dst_base;
            reg_count:     read_mux[count_width-1:0] = capture_count;
            default:       read_mux = '0;
        endcase
    end

    // readdata valid the cycle after the read strobe
    always_ff @(posedge clk) begin
        if (avs_s0_read) begin
            avs_s0_readdata <= read_mux;
        end
    end

endmodule

/* bpfcap_pkg.sv */
package bpfcap_pkg;

    // data word on every Avalon data port
    typedef logic [31:0] word_t;

    // byte address used by both masters
    typedef logic [31:0] addr_t;

    // slave register index
    typedef logic [2:0] reg_idx_t;

    // reader walks the range, then lets in-flight words settle
    typedef enum logic [1:0] {
        idle  = 2'd0,
        fetch = 2'd1,
        drain = 2'd2
    } reader_state_t;

    // slave register map
    localparam reg_idx_t reg_control   = 3'd0;
    localparam reg_idx_t reg_pkt_begin = 3'd1;
    localparam reg_idx_t reg_pkt_end   = 3'd2;
    localparam reg_idx_t reg_match     = 3'd3;
    localparam reg_idx_t reg_mask      = 3'd4;
    localparam reg_idx_t reg_dst_base  = 3'd5;
    localparam reg_idx_t reg_count     = 3'd6;

endpackage
